//--- soc_ifc_boot_defines.svh
`ifndef SOC_IFC_BOOT_DEFINES_SVH
`define SOC_IFC_BOOT_DEFINES_SVH

// fuse bank geometry
`define SOC_IFC_FUSE_WORDS 8
`define SOC_IFC_DATA_W 32

// register port address width
`define SOC_IFC_ADDR_W 8

// fuse words sit at base .. base+7, one word per address
`define ADDR_FUSE_BASE 8'h10
`define ADDR_FUSE_DONE 8'h18

// firmware update reset, trigger in bit 0
`define ADDR_FW_UPD_CTRL 8'h20
`define ADDR_FW_UPD_WAIT 8'h21

// debug continue bit and read-only status
`define ADDR_BOOT_CONTINUE 8'h22
`define ADDR_BOOT_STATUS 8'h23

// cycles the core is held during a firmware update reset
`define SOC_IFC_FW_WAIT_DEFAULT 8'd10

`endif

//--- soc_ifc_pkg.sv
package soc_ifc_pkg;

    // boot sequencer states
    typedef enum logic [2:0] {
        BOOT_IDLE   = 3'd0,
        // soc programs fuses here, everything else held in reset
        BOOT_FUSE   = 3'd1,
        // core held in reset for a firmware update
        BOOT_FW_RST = 3'd2,
        // timed hold, or parked on the debug breakpoint
        BOOT_WAIT   = 3'd3,
        BOOT_DONE   = 3'd4
    } boot_fsm_state_e;

    // reset and status outputs of the boot sequencer
    typedef struct packed {
        // reset for every block except the core
        logic cptra_noncore_rst_b;
        // core reset, also asserted by firmware update
        logic cptra_uc_rst_b;
        // one-cycle pulse at the end of each reset flow
        logic iccm_unlock;
        logic ready_for_fuses;
        // sticky once a firmware update reset has run
        logic fw_upd_rst_executed;
    } boot_rst_ctrl_t;

endpackage

//--- soc_ifc_reg_pkg.sv
`include "soc_ifc_boot_defines.svh"

package soc_ifc_reg_pkg;

    // register port opcodes
    typedef enum logic [1:0] {
        REG_NOP   = 2'd0,
        REG_READ  = 2'd1,
        REG_WRITE = 2'd2
    } reg_op_e;

    // request, valid for the single cycle where op is not nop
    typedef struct packed {
        reg_op_e                    op;
        logic [`SOC_IFC_ADDR_W-1:0] addr;
        logic [`SOC_IFC_DATA_W-1:0] wdata;
    } reg_req_t;

    // response, returned one cycle after the request
    typedef struct packed {
        logic                       rvalid;
        logic                       err;
        logic [`SOC_IFC_DATA_W-1:0] rdata;
    } reg_rsp_t;

    // decoded fuse word write toward the fuse bank
    typedef struct packed {
        logic                       wr;
        logic [2:0]                 idx;
        logic [`SOC_IFC_DATA_W-1:0] data;
    } fuse_wr_t;

endpackage

//--- soc_ifc_boot_fsm.sv
module soc_ifc_boot_fsm (
    input  logic                        clk,
    input  logic                        cptra_rst_b,
    input  logic                        fuse_done,
    input  logic                        fw_update_rst,
    input  logic [7:0]                  fw_update_rst_wait_cycles,
    input  logic                        boot_brkpoint,
    input  logic                        boot_continue,
    output soc_ifc_pkg::boot_rst_ctrl_t rst_ctrl
);

    soc_ifc_pkg::boot_fsm_state_e boot_fsm_ps;
    soc_ifc_pkg::boot_fsm_state_e boot_fsm_ns;

    // state transition arcs
    logic arc_fuse_to_done;
    logic arc_fuse_to_wait;
    logic arc_wait_to_done;
    logic arc_done_to_fw_rst;
    logic enter_done;

    // reset release stage
    logic propagate_en;
    logic fsm_uc_rst_b;
    logic synch_noncore_rst_b;
    logic synch_uc_rst_b;
    logic noncore_rst_q;
    logic uc_rst_q;

    logic iccm_unlock_q;
    logic fw_upd_rst_executed_q;

    // hold counter
    logic [7:0] wait_count;
    logic       wait_count_load;
    logic       wait_count_decr;

    // fuse done moves on, breakpoint picks the parked path
    assign arc_fuse_to_done = fuse_done & ~boot_brkpoint;
    assign arc_fuse_to_wait = fuse_done & boot_brkpoint;

    // counter expired and not parked on the breakpoint
    assign arc_wait_to_done = (wait_count == 8'd0) & ~(boot_brkpoint & ~boot_continue);
    assign arc_done_to_fw_rst = fw_update_rst;

    always_comb begin
        boot_fsm_ns     = boot_fsm_ps;
        wait_count_load = 1'b0;
        wait_count_decr = 1'b0;
        propagate_en    = 1'b0;
        fsm_uc_rst_b    = 1'b1;
        case (boot_fsm_ps)
            soc_ifc_pkg::BOOT_IDLE: begin
                boot_fsm_ns     = soc_ifc_pkg::BOOT_FUSE;
                wait_count_load = 1'b1;
            end
            soc_ifc_pkg::BOOT_FUSE: begin
                if (arc_fuse_to_wait) begin
                    boot_fsm_ns = soc_ifc_pkg::BOOT_WAIT;
                end else if (arc_fuse_to_done) begin
                    boot_fsm_ns = soc_ifc_pkg::BOOT_DONE;
                end
                wait_count_load = 1'b1;
                fsm_uc_rst_b    = 1'b0;
            end
            soc_ifc_pkg::BOOT_FW_RST: begin
                // core goes back into reset, timer starts
                boot_fsm_ns     = soc_ifc_pkg::BOOT_WAIT;
                wait_count_decr = 1'b1;
                fsm_uc_rst_b    = 1'b0;
            end
            soc_ifc_pkg::BOOT_WAIT: begin
                if (arc_wait_to_done) begin
                    boot_fsm_ns = soc_ifc_pkg::BOOT_DONE;
                end
                wait_count_decr = 1'b1;
                fsm_uc_rst_b    = 1'b0;
            end
            soc_ifc_pkg::BOOT_DONE: begin
                if (arc_done_to_fw_rst) begin
                    boot_fsm_ns = soc_ifc_pkg::BOOT_FW_RST;
                end
                // reload timer so the next update starts from the programmed count
                wait_count_load = 1'b1;
                propagate_en    = 1'b1;
            end
            default: begin
                boot_fsm_ns = soc_ifc_pkg::BOOT_IDLE;
            end
        endcase
    end

    // every entry into done ends a reset flow
    assign enter_done = (boot_fsm_ns == soc_ifc_pkg::BOOT_DONE) &&
                        (boot_fsm_ps != soc_ifc_pkg::BOOT_DONE);

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            boot_fsm_ps           <= soc_ifc_pkg::BOOT_IDLE;
            wait_count            <= 8'd0;
            synch_noncore_rst_b   <= 1'b0;
            synch_uc_rst_b        <= 1'b0;
            noncore_rst_q         <= 1'b0;
            uc_rst_q              <= 1'b0;
            iccm_unlock_q         <= 1'b0;
            fw_upd_rst_executed_q <= 1'b0;
        end else begin
            boot_fsm_ps <= boot_fsm_ns;
            if (wait_count_load) begin
                wait_count <= fw_update_rst_wait_cycles;
            end else if (wait_count_decr && (wait_count != 8'd0)) begin
                // stops at zero while parked on the breakpoint
                wait_count <= wait_count - 8'd1;
            end
            // first flop, noncore release is sticky once done is reached
            synch_noncore_rst_b <= synch_noncore_rst_b | propagate_en;
            synch_uc_rst_b      <= propagate_en | fsm_uc_rst_b;
            // second flop
            noncore_rst_q <= synch_noncore_rst_b;
            // core leaves reset only when global, firmware and synced terms agree
            uc_rst_q      <= synch_noncore_rst_b & fsm_uc_rst_b & synch_uc_rst_b;
            iccm_unlock_q <= enter_done;
            if ((boot_fsm_ps == soc_ifc_pkg::BOOT_DONE) && arc_done_to_fw_rst) begin
                fw_upd_rst_executed_q <= 1'b1;
            end
        end
    end

    assign rst_ctrl.cptra_noncore_rst_b = noncore_rst_q;
    assign rst_ctrl.cptra_uc_rst_b      = uc_rst_q;
    assign rst_ctrl.iccm_unlock         = iccm_unlock_q;
    assign rst_ctrl.ready_for_fuses     = (boot_fsm_ps == soc_ifc_pkg::BOOT_FUSE);
    assign rst_ctrl.fw_upd_rst_executed = fw_upd_rst_executed_q;

    state_known_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        !$isunknown(boot_fsm_ps));

    // noncore blocks stay in reset until fuses are done
    noncore_held_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        (boot_fsm_ps inside {soc_ifc_pkg::BOOT_IDLE, soc_ifc_pkg::BOOT_FUSE})
        |-> !rst_ctrl.cptra_noncore_rst_b);

    uc_held_in_wait_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        (boot_fsm_ps == soc_ifc_pkg::BOOT_WAIT) |-> !rst_ctrl.cptra_uc_rst_b);

endmodule

//--- soc_ifc_fuse_bank.sv
`include "soc_ifc_boot_defines.svh"

module soc_ifc_fuse_bank (
    input  logic                                                 clk,
    input  logic                                                 cptra_rst_b,
    input  soc_ifc_reg_pkg::fuse_wr_t                            fuse_wr,
    input  logic                                                 fuse_done_wr,
    input  logic [2:0]                                           fuse_rd_idx,
    input  logic                                                 ready_for_fuses,
    output logic [`SOC_IFC_DATA_W-1:0]                           fuse_rdata,
    output logic                                                 fuse_wr_rej,
    output logic                                                 fuse_done,
    output logic [`SOC_IFC_FUSE_WORDS-1:0][`SOC_IFC_DATA_W-1:0] fuse_words
);

    logic [`SOC_IFC_FUSE_WORDS-1:0][`SOC_IFC_DATA_W-1:0] fuse_q;
    logic                                                 wr_accept;

    // writes land only inside the fuse window and before the lock
    assign wr_accept   = fuse_wr.wr & ready_for_fuses & ~fuse_done;
    assign fuse_wr_rej = fuse_wr.wr & ~wr_accept;

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_q <= '0;
        end else if (wr_accept) begin
            fuse_q[fuse_wr.idx] <= fuse_wr.data;
        end
    end

    // done doubles as the lock, held until the next reset
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_done <= 1'b0;
        end else if (fuse_done_wr) begin
            fuse_done <= 1'b1;
        end
    end

    assign fuse_rdata = fuse_q[fuse_rd_idx];

    // whole bank for key consumers downstream
    assign fuse_words = fuse_q;

    fuse_locked_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        fuse_done |=> $stable(fuse_q));

endmodule

//--- soc_ifc_boot_regs.sv
`include "soc_ifc_boot_defines.svh"

module soc_ifc_boot_regs (
    input  logic                        clk,
    input  logic                        cptra_rst_b,
    input  soc_ifc_reg_pkg::reg_req_t   reg_req,
    input  logic [`SOC_IFC_DATA_W-1:0]  fuse_rdata,
    input  logic                        fuse_wr_rej,
    input  logic                        fuse_done,
    input  soc_ifc_pkg::boot_rst_ctrl_t rst_ctrl,
    output soc_ifc_reg_pkg::reg_rsp_t   reg_rsp,
    output soc_ifc_reg_pkg::fuse_wr_t   fuse_wr,
    output logic                        fuse_done_wr,
    output logic [2:0]                  fuse_rd_idx,
    output logic                        fw_update_rst,
    output logic [7:0]                  fw_update_rst_wait_cycles,
    output logic                        boot_continue
);

    logic is_rd;
    logic is_wr;
    logic hit_fuse;
    logic hit_done;
    logic hit_ctrl;
    logic hit_wait;
    logic hit_cont;
    logic hit_status;
    logic hit_any;
    logic req_err;

    logic [`SOC_IFC_DATA_W-1:0] rd_data;

    // response flops
    logic                       rsp_valid_q;
    logic                       rsp_err_q;
    logic [`SOC_IFC_DATA_W-1:0] rsp_rdata_q;

    assign is_rd = (reg_req.op == soc_ifc_reg_pkg::REG_READ);
    assign is_wr = (reg_req.op == soc_ifc_reg_pkg::REG_WRITE);

    // address decode
    assign hit_fuse   = (reg_req.addr >= `ADDR_FUSE_BASE) &&
                        (reg_req.addr < (`ADDR_FUSE_BASE + `SOC_IFC_FUSE_WORDS));
    assign hit_done   = (reg_req.addr == `ADDR_FUSE_DONE);
    assign hit_ctrl   = (reg_req.addr == `ADDR_FW_UPD_CTRL);
    assign hit_wait   = (reg_req.addr == `ADDR_FW_UPD_WAIT);
    assign hit_cont   = (reg_req.addr == `ADDR_BOOT_CONTINUE);
    assign hit_status = (reg_req.addr == `ADDR_BOOT_STATUS);
    assign hit_any    = hit_fuse | hit_done | hit_ctrl | hit_wait | hit_cont | hit_status;

    // fuse accesses pass straight through to the bank
    assign fuse_rd_idx  = 3'(reg_req.addr - `ADDR_FUSE_BASE);
    assign fuse_wr.wr   = is_wr & hit_fuse;
    assign fuse_wr.idx  = fuse_rd_idx;
    assign fuse_wr.data = reg_req.wdata;
    assign fuse_done_wr = is_wr & hit_done;

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fw_update_rst             <= 1'b0;
            fw_update_rst_wait_cycles <= `SOC_IFC_FW_WAIT_DEFAULT;
            boot_continue             <= 1'b0;
        end else begin
            // trigger is a single cycle pulse, nothing to clear
            fw_update_rst <= is_wr & hit_ctrl & reg_req.wdata[0];
            if (is_wr && hit_wait) begin
                fw_update_rst_wait_cycles <= reg_req.wdata[7:0];
            end
            // continue is sticky until reset
            if (is_wr && hit_cont && reg_req.wdata[0]) begin
                boot_continue <= 1'b1;
            end
        end
    end

    // read data mux, unmapped and control addresses read zero
    always_comb begin
        rd_data = '0;
        if (hit_fuse) begin
            rd_data = fuse_rdata;
        end else if (hit_done) begin
            rd_data[0] = fuse_done;
        end else if (hit_wait) begin
            rd_data[7:0] = fw_update_rst_wait_cycles;
        end else if (hit_cont) begin
            rd_data[0] = boot_continue;
        end else if (hit_status) begin
            // bit 5 fuse done, bits 4:0 reset control in struct order
            rd_data[5:0] = {fuse_done, rst_ctrl};
        end
    end

    assign req_err = ~hit_any | (is_wr & hit_status) | fuse_wr_rej;

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rsp_valid_q <= 1'b0;
            rsp_err_q   <= 1'b0;
        end else begin
            rsp_valid_q <= is_rd | is_wr;
            rsp_err_q   <= (is_rd | is_wr) & req_err;
        end
    end

    always_ff @(posedge clk) begin
        rsp_rdata_q <= is_rd ? rd_data : '0;
    end

    assign reg_rsp.rvalid = rsp_valid_q;
    assign reg_rsp.err    = rsp_err_q;
    assign reg_rsp.rdata  = rsp_rdata_q;

    rsp_one_per_req_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        reg_rsp.rvalid == $past(reg_req.op != soc_ifc_reg_pkg::REG_NOP));

endmodule

//--- soc_ifc_boot_top.sv
`include "soc_ifc_boot_defines.svh"

module soc_ifc_boot_top (
    input  logic                                                 clk,
    input  logic                                                 cptra_rst_b,
    input  soc_ifc_reg_pkg::reg_req_t                            reg_req,
    input  logic                                                 boot_brkpoint,
    output soc_ifc_reg_pkg::reg_rsp_t                            reg_rsp,
    output soc_ifc_pkg::boot_rst_ctrl_t                          rst_ctrl,
    output logic [`SOC_IFC_FUSE_WORDS-1:0][`SOC_IFC_DATA_W-1:0] fuse_words
);

    // register block to fuse bank
    soc_ifc_reg_pkg::fuse_wr_t  fuse_wr;
    logic                       fuse_done_wr;
    logic [2:0]                 fuse_rd_idx;
    logic [`SOC_IFC_DATA_W-1:0] fuse_rdata;
    logic                       fuse_wr_rej;
    logic                       fuse_done;

    // register block to boot sequencer
    logic       fw_update_rst;
    logic [7:0] fw_update_rst_wait_cycles;
    logic       boot_continue;

    soc_ifc_boot_fsm u_boot_fsm (
        .clk                       (clk),
        .cptra_rst_b               (cptra_rst_b),
        .fuse_done                 (fuse_done),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .boot_brkpoint             (boot_brkpoint),
        .boot_continue             (boot_continue),
        .rst_ctrl                  (rst_ctrl)
    );

    soc_ifc_fuse_bank u_fuse_bank (
        .clk             (clk),
        .cptra_rst_b     (cptra_rst_b),
        .fuse_wr         (fuse_wr),
        .fuse_done_wr    (fuse_done_wr),
        .fuse_rd_idx     (fuse_rd_idx),
        .ready_for_fuses (rst_ctrl.ready_for_fuses),
        .fuse_rdata      (fuse_rdata),
        .fuse_wr_rej     (fuse_wr_rej),
        .fuse_done       (fuse_done),
        .fuse_words      (fuse_words)
    );

    soc_ifc_boot_regs u_boot_regs (
        .clk                       (clk),
        .cptra_rst_b               (cptra_rst_b),
        .reg_req                   (reg_req),
        .fuse_rdata                (fuse_rdata),
        .fuse_wr_rej               (fuse_wr_rej),
        .fuse_done                 (fuse_done),
        .rst_ctrl                  (rst_ctrl),
        .reg_rsp                   (reg_rsp),
        .fuse_wr                   (fuse_wr),
        .fuse_done_wr              (fuse_done_wr),
        .fuse_rd_idx               (fuse_rd_idx),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .boot_continue             (boot_continue)
    );

endmodule

//--- soc_ifc_boot_tb_checks.svh
`ifndef SOC_IFC_BOOT_TB_CHECKS_SVH
`define SOC_IFC_BOOT_TB_CHECKS_SVH

// per-test and run-wide tallies
int    pass_count = 0;
int    fail_count = 0;
int    error_total = 0;
int    test_errors = 0;
string test_name = "reset";

task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
endtask

task automatic end_test();
    if (test_errors == 0) begin
        pass_count++;
        $display("test %s ok", test_name);
    end else begin
        fail_count++;
        $display("test %s failed with %0d errors", test_name, test_errors);
    end
endtask

task automatic note_error(input string msg);
    $display("error in %s: %s", test_name, msg);
    test_errors++;
    error_total++;
endtask

task automatic value_check(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
        $display("Fail %s %s expected %h actual %h", test_name, what, exp, act);
        test_errors++;
        error_total++;
    end
endtask

// status bits 5 down to 0 hold fuse done, noncore, core, iccm unlock, fuse window and update ran
function automatic logic [31:0] status_word(input logic done, input logic noncore,
                                            input logic uc, input logic fw_exec);
    status_word = {26'd0, done, noncore, uc, 1'b0, 1'b0, fw_exec};
endfunction

// noncore must sit in reset until the fuse done write has gone out
noncore_before_done_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    !done_written |-> !rst_ctrl.cptra_noncore_rst_b)
    else note_error("noncore reset released before the fuse done write");

// entry into done from a cold flow releases both resets two edges later
release_two_edges_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    ($rose(rst_ctrl.iccm_unlock) && !rst_ctrl.cptra_noncore_rst_b) |=>
    !rst_ctrl.cptra_noncore_rst_b ##1
    (rst_ctrl.cptra_noncore_rst_b && rst_ctrl.cptra_uc_rst_b))
    else note_error("resets not released exactly two edges after entering done");

iccm_one_cycle_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    rst_ctrl.iccm_unlock |=> !rst_ctrl.iccm_unlock)
    else note_error("iccm unlock held for more than one cycle");

// every core release is preceded by the unlock pulse
iccm_before_uc_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $rose(rst_ctrl.cptra_uc_rst_b) |-> $past(rst_ctrl.iccm_unlock, 2))
    else note_error("core reset released without a preceding iccm unlock pulse");

// nothing leaves reset while parked on the breakpoint
brk_hold_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    (boot_brkpoint && done_written && !cont_written) |->
    (!rst_ctrl.cptra_noncore_rst_b && !rst_ctrl.cptra_uc_rst_b))
    else note_error("reset released while parked on the breakpoint");

// firmware update drops only the core for at least the programmed count
fw_core_only_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    ($fell(rst_ctrl.cptra_uc_rst_b) && rst_ctrl.cptra_noncore_rst_b) |->
    (rst_ctrl.cptra_noncore_rst_b && !rst_ctrl.cptra_uc_rst_b) [*FW_WAIT])
    else note_error("core reset too short or noncore dropped during firmware update");

`endif

//--- soc_ifc_boot_tb.sv
`include "soc_ifc_boot_defines.svh"

module soc_ifc_boot_tb;

    localparam int         TIMEOUT       = 200;
    localparam int         FW_WAIT       = 6;
    localparam logic [7:0] ADDR_UNMAPPED = 8'h40;

    logic                                                 clk;
    logic                                                 cptra_rst_b;
    soc_ifc_reg_pkg::reg_req_t                            reg_req;
    logic                                                 boot_brkpoint;
    soc_ifc_reg_pkg::reg_rsp_t                            reg_rsp;
    soc_ifc_pkg::boot_rst_ctrl_t                          rst_ctrl;
    logic [`SOC_IFC_FUSE_WORDS-1:0][`SOC_IFC_DATA_W-1:0] fuse_words;

    // reference model state
    integer      seed;
    logic [31:0] fuse_exp [`SOC_IFC_FUSE_WORDS];
    logic        done_written;
    logic        cont_written;
    int          iccm_pulses = 0;
    int          iccm_mark;
    logic [31:0] rd_val;
    logic        rd_err;

    `include "soc_ifc_boot_tb_checks.svh"

    soc_ifc_boot_top uut (
        .clk           (clk),
        .cptra_rst_b   (cptra_rst_b),
        .reg_req       (reg_req),
        .boot_brkpoint (boot_brkpoint),
        .reg_rsp       (reg_rsp),
        .rst_ctrl      (rst_ctrl),
        .fuse_words    (fuse_words)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // running count of unlock pulses, one falling edge per pulse
    always @(negedge clk) begin
        iccm_pulses <= iccm_pulses + int'(rst_ctrl.iccm_unlock);
    end

    task automatic finish_run();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 pass_count, fail_count, error_total);
        if (error_total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic abort_run(input string msg);
        note_error(msg);
        finish_run();
    endtask

    // reset held low for two rising edges and released one unit after the second
    task automatic apply_reset(input logic brk);
        cptra_rst_b   = 1'b0;
        boot_brkpoint = brk;
        reg_req.op    = soc_ifc_reg_pkg::REG_NOP;
        reg_req.addr  = '0;
        reg_req.wdata = '0;
        done_written  = 1'b0;
        cont_written  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        cptra_rst_b = 1'b1;
    endtask

    // drive one request and poll for its response
    task automatic reg_access(input soc_ifc_reg_pkg::reg_op_e op, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int n;
        reg_req.op    = op;
        reg_req.addr  = addr;
        reg_req.wdata = wdata;
        @(posedge clk);
        #1;
        reg_req.op = soc_ifc_reg_pkg::REG_NOP;
        n = 0;
        while (!reg_rsp.rvalid && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!reg_rsp.rvalid) begin
            abort_run("no register response within the timeout");
        end else begin
            rdata = reg_rsp.rdata;
            err   = reg_rsp.err;
        end
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata);
        reg_access(soc_ifc_reg_pkg::REG_WRITE, addr, wdata, rd_val, rd_err);
    endtask

    task automatic reg_read(input logic [7:0] addr);
        reg_access(soc_ifc_reg_pkg::REG_READ, addr, 32'd0, rd_val, rd_err);
    endtask

    task automatic wait_fuse_window();
        int n;
        n = 0;
        while (!rst_ctrl.ready_for_fuses && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!rst_ctrl.ready_for_fuses) begin
            abort_run("fuse window never opened");
        end
    endtask

    task automatic wait_core_reset(input logic level);
        int n;
        n = 0;
        while (rst_ctrl.cptra_uc_rst_b !== level && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (rst_ctrl.cptra_uc_rst_b !== level) begin
            abort_run("core reset did not change within the timeout");
        end
    endtask

    // random words in and read back through both ports
    task automatic load_fuses();
        for (int i = 0; i < `SOC_IFC_FUSE_WORDS; i++) begin
            fuse_exp[i] = $random(seed);
            reg_write(`ADDR_FUSE_BASE + i, fuse_exp[i]);
            value_check("fuse write err", 32'd0, rd_err);
        end
        for (int i = 0; i < `SOC_IFC_FUSE_WORDS; i++) begin
            reg_read(`ADDR_FUSE_BASE + i);
            value_check("fuse readback", fuse_exp[i], rd_val);
            value_check("fuse_words", fuse_exp[i], fuse_words[i]);
        end
    endtask

    initial begin
        seed      = 97;
        iccm_mark = 0;
        apply_reset(1'b0);

        start_test("fuse_load");
        wait_fuse_window();
        load_fuses();
        done_written = 1'b1;
        reg_write(`ADDR_FUSE_DONE, 32'd1);
        wait_core_reset(1'b1);
        value_check("noncore reset", 32'd1, rst_ctrl.cptra_noncore_rst_b);
        reg_read(`ADDR_BOOT_STATUS);
        value_check("boot status", status_word(1'b1, 1'b1, 1'b1, 1'b0), rd_val);
        end_test();

        start_test("fuse_lock");
        reg_write(`ADDR_FUSE_BASE + 2, ~fuse_exp[2]);
        value_check("locked write err", 32'd1, rd_err);
        reg_read(`ADDR_FUSE_BASE + 2);
        value_check("locked readback", fuse_exp[2], rd_val);
        value_check("locked fuse_words", fuse_exp[2], fuse_words[2]);
        end_test();

        start_test("breakpoint_hold");
        apply_reset(1'b1);
        wait_fuse_window();
        load_fuses();
        done_written = 1'b1;
        reg_write(`ADDR_FUSE_DONE, 32'd1);
        // timer runs out in the first half and the FSM stays parked
        repeat (20) @(posedge clk);
        #1;
        value_check("parked core reset", 32'd0, rst_ctrl.cptra_uc_rst_b);
        iccm_mark    = iccm_pulses;
        cont_written = 1'b1;
        reg_write(`ADDR_BOOT_CONTINUE, 32'd1);
        wait_core_reset(1'b1);
        value_check("noncore after continue", 32'd1, rst_ctrl.cptra_noncore_rst_b);
        value_check("unlock pulses", 32'd1, iccm_pulses - iccm_mark);
        end_test();

        start_test("fw_update");
        reg_write(`ADDR_FW_UPD_WAIT, FW_WAIT);
        iccm_mark = iccm_pulses;
        reg_write(`ADDR_FW_UPD_CTRL, 32'd1);
        wait_core_reset(1'b0);
        value_check("noncore during update", 32'd1, rst_ctrl.cptra_noncore_rst_b);
        wait_core_reset(1'b1);
        value_check("unlock pulses", 32'd1, iccm_pulses - iccm_mark);
        reg_read(`ADDR_BOOT_STATUS);
        value_check("boot status", status_word(1'b1, 1'b1, 1'b1, 1'b1), rd_val);
        end_test();

        start_test("decode_errors");
        reg_read(ADDR_UNMAPPED);
        value_check("unmapped read err", 32'd1, rd_err);
        reg_write(`ADDR_BOOT_STATUS, 32'hffff_ffff);
        value_check("status write err", 32'd1, rd_err);
        reg_read(`ADDR_FW_UPD_WAIT);
        value_check("wait read err", 32'd0, rd_err);
        value_check("wait readback", FW_WAIT, rd_val);
        end_test();

        finish_run();
    end

endmodule

//--- soc_ifc_boot_top.f
+incdir+.
soc_ifc_pkg.sv
soc_ifc_reg_pkg.sv
soc_ifc_boot_fsm.sv
soc_ifc_fuse_bank.sv
soc_ifc_boot_regs.sv
soc_ifc_boot_top.sv
soc_ifc_boot_tb.sv
